/* logic/otp_lci_params.svh */
`ifndef OTP_LCI_PARAMS_SVH
`define OTP_LCI_PARAMS_SVH

// Native OTP word width in bits
`define OTP_WIDTH 16

// Word address width, covers the whole 64 word array
`define OTP_ADDR_WIDTH 6

// Native words in the life cycle partition
`define LC_NUM_WORDS 4

// Word address of the first life cycle word
`define LC_OFFSET 40

// Cycles from write grant to response valid
`define OTP_WR_LATENCY 3

`endif

/* logic/otp_lci_pkg.sv */
`include "otp_lci_params.svh"

package otp_lci_pkg;

  // Width of the word index within the partition
  localparam int LcCntWidth = $clog2(`LC_NUM_WORDS);

  // Plain vector types
  typedef logic [`OTP_WIDTH-1:0]               otp_word_t;
  typedef logic [`OTP_ADDR_WIDTH-1:0]          otp_addr_t;
  typedef logic [`LC_NUM_WORDS*`OTP_WIDTH-1:0] lc_data_t;
  typedef logic [LcCntWidth-1:0]               lc_cnt_t;

  // Error codes, values follow the full controller numbering
  typedef enum logic [2:0] {
    NoError              = 3'h0,
    MacroWriteBlankError = 3'h4,
    FsmStateError        = 3'h7
  } otp_err_e;

  // OTP macro command
  typedef enum logic {
    Read  = 1'b0,
    Write = 1'b1
  } otp_cmd_e;

  // Multibit escalation, anything but the off pattern escalates
  typedef logic [3:0] esc_t;
  localparam esc_t EscOff = 4'b1010;

  // Sparse interface FSM encoding
  // Minimum Hamming distance 5 between any two states
  typedef enum logic [8:0] {
    ResetSt     = 9'b000101011,
    IdleSt      = 9'b110011110,
    WriteSt     = 9'b101010001,
    WriteWaitSt = 9'b010000000,
    ErrorSt     = 9'b011111101
  } lci_state_e;

endpackage

/* logic/otp_lci_cnt.sv */
`timescale 1ns/1ps

module otp_lci_cnt (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clr_i,
  input  logic                 incr_i,
  output otp_lci_pkg::lc_cnt_t cnt_o,
  output logic                 err_o
);

  //////////////////////////////////////////////////////////////////////
  // Redundant counter copies
  //////////////////////////////////////////////////////////////////////

  // Up copy counts words, down copy mirrors it from all ones
  otp_lci_pkg::lc_cnt_t up_q, down_q;
  otp_lci_pkg::lc_cnt_t up_d, down_d;
  otp_lci_pkg::lc_cnt_t cnt_sum;

  always_comb begin
    up_d   = up_q;
    down_d = down_q;
    // Clear wins over increment
    if (clr_i) begin
      up_d   = '0;
      down_d = '1;
    end else if (incr_i) begin
      up_d   = up_q + 1'b1;
      down_d = down_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_q   <= '0;
      down_q <= '1;
    end else begin
      up_q   <= up_d;
      down_q <= down_d;
    end
  end

  // Both copies must always add up to all ones
  // A flipped bit in either copy breaks the sum
  assign cnt_sum = up_q + down_q;
  assign err_o   = (cnt_sum != '1);

  assign cnt_o = up_q;

endmodule

/* logic/otp_lci.sv */
`timescale 1ns/1ps
`include "otp_lci_params.svh"

module otp_lci (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   lci_en_i,
  input  otp_lci_pkg::esc_t      escalate_en_i,
  // Life cycle controller side
  input  logic                   lc_req_i,
  input  otp_lci_pkg::lc_data_t  lc_data_i,
  output logic                   lc_ack_o,
  output logic                   lc_err_o,
  // Status
  output otp_lci_pkg::otp_err_e  error_o,
  output logic                   fsm_err_o,
  output logic                   lci_prog_idle_o,
  // OTP macro side
  output logic                   otp_req_o,
  output otp_lci_pkg::otp_cmd_e  otp_cmd_o,
  output otp_lci_pkg::otp_addr_t otp_addr_o,
  output otp_lci_pkg::otp_word_t otp_wdata_o,
  input  logic                   otp_gnt_i,
  input  logic                   otp_rvalid_i,
  input  otp_lci_pkg::otp_err_e  otp_err_i
);

  // Index of the final word in the partition
  localparam otp_lci_pkg::lc_cnt_t LastWord = otp_lci_pkg::lc_cnt_t'(`LC_NUM_WORDS - 1);

  otp_lci_pkg::lci_state_e state_d, state_q;
  otp_lci_pkg::otp_err_e   error_d, error_q;
  otp_lci_pkg::lc_cnt_t    cnt;
  logic                    cnt_clr, cnt_incr, cnt_err;
  logic                    escalate;

  // Partition image split into native words
  logic [`LC_NUM_WORDS-1:0][`OTP_WIDTH-1:0] data;

  assign escalate = (escalate_en_i != otp_lci_pkg::EscOff);
  assign error_o  = error_q;

  //////////////////////////////////////////////////////////////////////
  // Interface FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    error_d = error_q;

    // Counter control
    cnt_clr  = 1'b0;
    cnt_incr = 1'b0;

    // Only idle when waiting for a request
    lci_prog_idle_o = 1'b0;

    // OTP request defaults
    otp_req_o = 1'b0;
    otp_cmd_o = otp_lci_pkg::Read;

    // Life cycle response
    lc_ack_o  = 1'b0;
    lc_err_o  = 1'b0;
    fsm_err_o = 1'b0;

    unique case (state_q)
      // Hold here until the interface gets enabled
      otp_lci_pkg::ResetSt: begin
        if (lci_en_i) begin
          state_d = otp_lci_pkg::IdleSt;
        end
      end

      // Wait for a transition request
      otp_lci_pkg::IdleSt: begin
        lci_prog_idle_o = 1'b1;
        if (lc_req_i) begin
          state_d = otp_lci_pkg::WriteSt;
          cnt_clr = 1'b1;
        end
      end

      // Issue one word write, stall until granted
      otp_lci_pkg::WriteSt: begin
        otp_req_o = 1'b1;
        otp_cmd_o = otp_lci_pkg::Write;
        if (otp_gnt_i) begin
          state_d = otp_lci_pkg::WriteWaitSt;
        end
      end

      // Wait for the write response
      otp_lci_pkg::WriteWaitSt: begin
        if (otp_rvalid_i) begin
          // Latch any error but keep burning the remaining words
          if (otp_err_i != otp_lci_pkg::NoError) begin
            error_d = otp_err_i;
          end
          if (cnt == LastWord) begin
            // All words done, answer the life cycle controller
            lc_ack_o = 1'b1;
            state_d  = otp_lci_pkg::IdleSt;
            if (error_d != otp_lci_pkg::NoError) begin
              lc_err_o = 1'b1;
              state_d  = otp_lci_pkg::ErrorSt;
            end
          end else begin
            // Move on to the next word
            cnt_incr = 1'b1;
            state_d  = otp_lci_pkg::WriteSt;
          end
        end
      end

      // Terminal lock, never answers again
      otp_lci_pkg::ErrorSt: begin
        if (error_q == otp_lci_pkg::NoError) begin
          error_d = otp_lci_pkg::FsmStateError;
        end
      end

      // Glitched into an undefined encoding
      default: begin
        state_d   = otp_lci_pkg::ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation or counter fault overrides everything
    if (escalate || cnt_err) begin
      state_d   = otp_lci_pkg::ErrorSt;
      fsm_err_o = 1'b1;
      // Keep an earlier error code visible
      if (error_q == otp_lci_pkg::NoError) begin
        error_d = otp_lci_pkg::FsmStateError;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Word counter and write datapath
  //////////////////////////////////////////////////////////////////////

  otp_lci_cnt u_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (cnt_clr),
    .incr_i (cnt_incr),
    .cnt_o  (cnt),
    .err_o  (cnt_err)
  );

  // Partition base plus current word index
  assign otp_addr_o = otp_lci_pkg::otp_addr_t'(`LC_OFFSET) + otp_lci_pkg::otp_addr_t'(cnt);

  assign data = lc_data_i;

  // Data bus stays quiet outside a request
  assign otp_wdata_o = otp_req_o ? otp_lci_pkg::otp_word_t'(data[cnt]) : '0;

  //////////////////////////////////////////////////////////////////////
  // State and error registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= otp_lci_pkg::ResetSt;
      error_q <= otp_lci_pkg::NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

endmodule

/* logic/otp_macro.sv */
`timescale 1ns/1ps
`include "otp_lci_params.svh"

module otp_macro (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   otp_req_i,
  input  otp_lci_pkg::otp_cmd_e  otp_cmd_i,
  input  otp_lci_pkg::otp_addr_t otp_addr_i,
  input  otp_lci_pkg::otp_word_t otp_wdata_i,
  output logic                   otp_gnt_o,
  output logic                   otp_rvalid_o,
  output otp_lci_pkg::otp_err_e  otp_err_o,
  output otp_lci_pkg::lc_data_t  lc_state_o
);

  localparam int NumWords = 2 ** `OTP_ADDR_WIDTH;
  localparam int LatWidth = $clog2(`OTP_WR_LATENCY + 1);

  // Behavioral fuse array
  otp_lci_pkg::otp_word_t mem [NumWords];

  // Pending command
  logic                   busy_q;
  logic [LatWidth-1:0]    lat_q;
  otp_lci_pkg::otp_cmd_e  cmd_q;
  otp_lci_pkg::otp_addr_t addr_q;
  otp_lci_pkg::otp_word_t wdata_q;
  logic                   blank_fail;

  //////////////////////////////////////////////////////////////////////
  // Request handling
  //////////////////////////////////////////////////////////////////////

  // Accept only while nothing is in flight
  assign otp_gnt_o = otp_req_i && !busy_q;

  // Response on the last latency cycle
  assign otp_rvalid_o = busy_q && (lat_q == '0);

  // A zero over a programmed bit cannot be burned
  assign blank_fail = |(mem[addr_q] & ~wdata_q);

  always_comb begin
    otp_err_o = otp_lci_pkg::NoError;
    if (otp_rvalid_o && (cmd_q == otp_lci_pkg::Write) && blank_fail) begin
      otp_err_o = otp_lci_pkg::MacroWriteBlankError;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      lat_q  <= '0;
    end else if (otp_gnt_o) begin
      busy_q <= 1'b1;
      lat_q  <= LatWidth'(`OTP_WR_LATENCY - 1);
    end else if (otp_rvalid_o) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      lat_q <= lat_q - 1'b1;
    end
  end

  // Command payload captured at grant
  always_ff @(posedge clk_i) begin
    if (otp_gnt_o) begin
      cmd_q   <= otp_cmd_i;
      addr_q  <= otp_addr_i;
      wdata_q <= otp_wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fuse array
  //////////////////////////////////////////////////////////////////////

  // Blank after reset, bits can only be set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumWords; i++) begin
        mem[i] <= '0;
      end
    end else if (otp_rvalid_o && (cmd_q == otp_lci_pkg::Write)) begin
      mem[addr_q] <= mem[addr_q] | wdata_q;
    end
  end

  // Life cycle partition readout, word 0 in the low bits
  always_comb begin
    for (int i = 0; i < `LC_NUM_WORDS; i++) begin
      lc_state_o[i*`OTP_WIDTH +: `OTP_WIDTH] = mem[`LC_OFFSET + i];
    end
  end

endmodule

/* logic/otp_lci_top.sv */
`timescale 1ns/1ps

module otp_lci_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  lci_en_i,
  input  otp_lci_pkg::esc_t     escalate_en_i,
  // Life cycle controller side
  input  logic                  lc_req_i,
  input  otp_lci_pkg::lc_data_t lc_data_i,
  output logic                  lc_ack_o,
  output logic                  lc_err_o,
  output otp_lci_pkg::lc_data_t lc_state_o,
  // Status
  output otp_lci_pkg::otp_err_e error_o,
  output logic                  fsm_err_o,
  output logic                  lci_prog_idle_o
);

  // Interface to macro wires
  logic                   otp_req;
  otp_lci_pkg::otp_cmd_e  otp_cmd;
  otp_lci_pkg::otp_addr_t otp_addr;
  otp_lci_pkg::otp_word_t otp_wdata;
  logic                   otp_gnt;
  logic                   otp_rvalid;
  otp_lci_pkg::otp_err_e  otp_err;

  otp_lci u_lci (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o),
    .otp_req_o       (otp_req),
    .otp_cmd_o       (otp_cmd),
    .otp_addr_o      (otp_addr),
    .otp_wdata_o     (otp_wdata),
    .otp_gnt_i       (otp_gnt),
    .otp_rvalid_i    (otp_rvalid),
    .otp_err_i       (otp_err)
  );

  // Behavioral macro, also feeds the partition readout
  otp_macro u_macro (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .otp_req_i    (otp_req),
    .otp_cmd_i    (otp_cmd),
    .otp_addr_i   (otp_addr),
    .otp_wdata_i  (otp_wdata),
    .otp_gnt_o    (otp_gnt),
    .otp_rvalid_o (otp_rvalid),
    .otp_err_o    (otp_err),
    .lc_state_o   (lc_state_o)
  );

endmodule

/* verif/otp_lci_sva.sv */
`timescale 1ns/1ps

module otp_lci_sva (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    lc_ack_i,
  input logic                    lc_err_i,
  input logic                    otp_req_i,
  input logic                    otp_gnt_i,
  input otp_lci_pkg::lci_state_e state_i
);

  // Number of failed assertions
  int fail_cnt = 0;

  //////////////////////////////////////////////////////////////////////
  // Life cycle handshake
  //////////////////////////////////////////////////////////////////////

  // Acknowledge is a single cycle pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lc_ack_i |=> !lc_ack_i)
    else begin
      $error("lc_ack_o high for more than one cycle");
      fail_cnt++;
    end

  // Error flag only rides on an acknowledge
  err_with_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lc_err_i |-> lc_ack_i)
    else begin
      $error("lc_err_o without lc_ack_o");
      fail_cnt++;
    end

  //////////////////////////////////////////////////////////////////////
  // OTP request and terminal state
  //////////////////////////////////////////////////////////////////////

  // Request stays up until granted
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_req_i && !otp_gnt_i |=> otp_req_i)
    else begin
      $error("otp_req dropped before grant");
      fail_cnt++;
    end

  // Terminal lock never answers
  no_ack_in_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == otp_lci_pkg::ErrorSt |-> !lc_ack_i)
    else begin
      $error("acknowledge in ErrorSt");
      fail_cnt++;
    end

endmodule

// Attach to every interface FSM
bind otp_lci otp_lci_sva u_lci_sva (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .lc_ack_i  (lc_ack_o),
  .lc_err_i  (lc_err_o),
  .otp_req_i (otp_req_o),
  .otp_gnt_i (otp_gnt_i),
  .state_i   (state_q)
);

/* verif/otp_lci_tb.sv */
`timescale 1ns/1ps
`include "otp_lci_params.svh"

module otp_lci_tb;

  // A transition burns every word with one grant plus the latency per word
  localparam int TransCycles  = `LC_NUM_WORDS * (`OTP_WR_LATENCY + 1);
  localparam int TransTimeout = 2 * TransCycles + 4;
  localparam int NumTests     = 5;
  localparam int NumTrans     = 8;
  localparam int ResetCycles  = 8;
  localparam int WatchdogCycles =
    2 * (NumTests * NumTrans * TransCycles + NumTests * ResetCycles);

  logic                  clk_i;
  logic                  rst_ni;
  logic                  lci_en_i;
  logic                  lc_req_i;
  otp_lci_pkg::esc_t     escalate_en_i;
  otp_lci_pkg::lc_data_t lc_data_i;
  otp_lci_pkg::lc_data_t lc_state_o;
  logic                  lc_ack_o;
  logic                  lc_err_o;
  logic                  fsm_err_o;
  logic                  lci_prog_idle_o;
  otp_lci_pkg::otp_err_e error_o;

  // Shadow image of the partition
  otp_lci_pkg::lc_data_t shadow;
  logic [31:0]           rng_state;
  int                    errors;
  int                    checks;
  int                    tests_run;
  int                    test_errors;
  string                 test_name;

  otp_lci_top u_otp_lci_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .lc_state_o      (lc_state_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o)
  );

  // 20 ns clock
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic otp_lci_pkg::lc_data_t rand_image();
    otp_lci_pkg::lc_data_t img;
    img[31:0]  = next_rand();
    img[63:32] = next_rand();
    return img;
  endfunction

  // OR into the shadow and flag any bit that would have to be cleared
  function automatic logic model_apply(input otp_lci_pkg::lc_data_t data);
    logic clears;
    clears = |(shadow & ~data);
    shadow = shadow | data;
    return clears;
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond === 1'b1) else begin
      $display("Error in %s: %s", test_name, msg);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == test_errors) begin
      $display("Test %s: ok", test_name);
    end else begin
      $display("Test %s: %0d errors", test_name, errors - test_errors);
    end
  endtask

  // Reset clears the FSM and blanks the macro array
  task automatic reset_dut();
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    lc_req_i      = 1'b0;
    lc_data_i     = '0;
    escalate_en_i = otp_lci_pkg::EscOff;
    shadow        = '0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
  endtask

  task automatic enable_lci();
    lci_en_i = 1'b1;
    @(negedge clk_i);
  endtask

  // Level request held until the acknowledge pulse or timeout
  // One extra cycle lets the array and the FSM settle
  task automatic run_transition(input otp_lci_pkg::lc_data_t data, output logic acked,
                                output logic err, output int cycles);
    acked     = 1'b0;
    err       = 1'b0;
    cycles    = 0;
    lc_data_i = data;
    lc_req_i  = 1'b1;
    while (!acked && cycles < TransTimeout) begin
      @(negedge clk_i);
      cycles++;
      if (lc_ack_o) begin
        acked = 1'b1;
        err   = lc_err_o;
      end
    end
    lc_req_i = 1'b0;
    @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_enable();
    logic acked;
    logic err;
    int   cycles;
    start_test("enable");
    reset_dut();
    check_value("lci_prog_idle_o", 1'b0, lci_prog_idle_o);
    check_value("fsm_err_o", 1'b0, fsm_err_o);
    check_value("error_o", otp_lci_pkg::NoError, error_o);
    run_transition(rand_image(), acked, err, cycles);
    check_true(!acked, "request acknowledged before enable");
    enable_lci();
    check_value("lci_prog_idle_o", 1'b1, lci_prog_idle_o);
    finish_test();
  endtask

  task automatic test_monotonic();
    otp_lci_pkg::lc_data_t image;
    logic exp_err;
    logic acked;
    logic err;
    int   cycles;
    start_test("monotonic");
    reset_dut();
    enable_lci();
    for (int i = 0; i < NumTrans; i++) begin
      // Only ever adds bits on top of the shadow
      image   = shadow | rand_image();
      exp_err = model_apply(image);
      run_transition(image, acked, err, cycles);
      check_true(acked, "transition got no acknowledge");
      check_value("ack latency", TransCycles, cycles);
      check_value("lc_err_o", exp_err, err);
      check_value("lc_state_o", shadow, lc_state_o);
      check_value("error_o", exp_err ? otp_lci_pkg::MacroWriteBlankError :
                  otp_lci_pkg::NoError, error_o);
    end
    finish_test();
  endtask

  // Second image clears bits of the first and may be followed by escalation
  task automatic test_blank_error(input string name, input logic escalate_after);
    otp_lci_pkg::lc_data_t first;
    otp_lci_pkg::lc_data_t second;
    logic exp_err;
    logic acked;
    logic err;
    int   cycles;
    start_test(name);
    reset_dut();
    enable_lci();
    first = rand_image() | 64'h1;
    void'(model_apply(first));
    run_transition(first, acked, err, cycles);
    second  = rand_image() & ~first;
    exp_err = model_apply(second);
    run_transition(second, acked, err, cycles);
    check_true(acked, "blank check transition got no acknowledge");
    check_value("lc_err_o", exp_err, err);
    check_value("error_o", exp_err ? otp_lci_pkg::MacroWriteBlankError :
                otp_lci_pkg::NoError, error_o);
    // All words still written, so the array holds both images
    check_value("lc_state_o", shadow, lc_state_o);
    if (escalate_after) begin
      escalate_en_i = ~otp_lci_pkg::EscOff;
      @(negedge clk_i);
      check_value("fsm_err_o", 1'b1, fsm_err_o);
      check_value("error_o", otp_lci_pkg::MacroWriteBlankError, error_o);
    end
    run_transition(rand_image(), acked, err, cycles);
    check_true(!acked, "request acknowledged after blank error");
    finish_test();
  endtask

  task automatic test_escalation();
    otp_lci_pkg::esc_t esc;
    logic acked;
    logic err;
    int   cycles;
    int   delay;
    start_test("escalation");
    reset_dut();
    enable_lci();
    lc_data_i = rand_image();
    lc_req_i  = 1'b1;
    // Hit somewhere in the middle of the word writes
    delay = 2 + int'(next_rand() % 8);
    repeat (delay) @(negedge clk_i);
    esc = otp_lci_pkg::esc_t'(next_rand());
    if (esc == otp_lci_pkg::EscOff) begin
      esc = ~otp_lci_pkg::EscOff;
    end
    escalate_en_i = esc;
    run_transition(lc_data_i, acked, err, cycles);
    check_true(!acked, "acknowledge after escalation");
    check_value("fsm_err_o", 1'b1, fsm_err_o);
    check_value("error_o", otp_lci_pkg::FsmStateError, error_o);
    check_value("lci_prog_idle_o", 1'b0, lci_prog_idle_o);
    finish_test();
  endtask

  initial begin
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    lc_req_i      = 1'b0;
    lc_data_i     = '0;
    escalate_en_i = otp_lci_pkg::EscOff;
    rng_state     = 32'h9033b1b5;
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    test_enable();
    test_monotonic();
    test_blank_error("blank_error", 1'b0);
    test_escalation();
    test_blank_error("escalate_after_blank", 1'b1);
    // Failures seen by the bound FSM checker
    if (u_otp_lci_top.u_lci.u_lci_sva.fail_cnt != 0) begin
      $display("Error: %0d concurrent assertion failures in the FSM checker",
               u_otp_lci_top.u_lci.u_lci_sva.fail_cnt);
      errors += u_otp_lci_top.u_lci.u_lci_sva.fail_cnt;
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog against a stuck handshake
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Error: watchdog expired after %0d cycles", WatchdogCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+logic
logic/otp_lci_pkg.sv
logic/otp_lci_cnt.sv
logic/otp_lci.sv
logic/otp_macro.sv
logic/otp_lci_top.sv
verif/otp_lci_sva.sv
verif/otp_lci_tb.sv

/* Bender.yml */
package:
  name: otp_lci

sources:
  - include_dirs:
      - logic
    files:
      - logic/otp_lci_pkg.sv
      - logic/otp_lci_cnt.sv
      - logic/otp_lci.sv
      - logic/otp_macro.sv
      - logic/otp_lci_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/otp_lci_sva.sv
      - verif/otp_lci_tb.sv
